// ==== bench/rename_retire_tests.svh ====
// Inputs go idle 10 ns after each rising edge
task automatic step();
    @(posedge clock);
    #10;
    disp_valid = 1'b0;
    wb_valid   = 1'b0;
endtask

task automatic dispatch_one(input logic wen, input arch_reg_t arch, output dispatch_rsp_t rsp);
    dispatch_rsp_t exp;
    rob_entry_t    entry;
    step();
    disp_valid       = 1'b1;
    disp_req.rd_wen  = wen;
    disp_req.rd_arch = arch;
    #1;
    // Request held until accepted
    while (!disp_ready) begin
        @(posedge clock);
        #11;
    end
    exp.rob_idx = ref_tail;
    exp.new_prf = lowest_free();
    exp.old_prf = ref_spec_map[arch];
    check_idx("disp_rsp_o.rob_idx", disp_rsp.rob_idx, exp.rob_idx);
    check_phys("disp_rsp_o.new_prf", disp_rsp.new_prf, exp.new_prf);
    check_phys("disp_rsp_o.old_prf", disp_rsp.old_prf, exp.old_prf);
    rsp = disp_rsp;
    entry                 = '0;
    entry.valid           = 1'b1;
    entry.payload.rd_wen  = wen;
    entry.payload.rd_arch = arch;
    entry.payload.new_prf = exp.new_prf;
    entry.payload.old_prf = exp.old_prf;
    ref_rob.push_back(entry);
    ref_tail = ref_tail + 1'b1;
    if (wen) begin
        ref_spec_map[arch]           = exp.new_prf;
        ref_spec_free[exp.new_prf] = 1'b0;
    end
endtask

// One cycle pulse, released before the entry can retire
task automatic writeback(input rob_idx_t idx, input logic mispred);
    rob_idx_t   offset;
    rob_entry_t entry;
    step();
    wb_valid     = 1'b1;
    wb.rob_idx   = idx;
    wb.exception = 1'b0;
    wb.mispred   = mispred;
    offset = idx - ref_head;
    if (int'(offset) < ref_rob.size()) begin
        entry         = ref_rob[offset];
        entry.done    = 1'b1;
        entry.mispred = mispred;
        ref_rob[offset] = entry;
    end else begin
        other_errors++;
        $display("Writeback at %0t to ROB slot %0d which holds nothing", $time, idx);
    end
    @(posedge clock);
    #10;
    wb_valid = 1'b0;
endtask

// Complete everything outstanding and wait until it has all retired
task automatic drain();
    rob_idx_t pending [$];
    int       target;
    for (int i = 0; i < ref_rob.size(); i++) begin
        if (!ref_rob[i].done) begin
            pending.push_back(rob_idx_t'(ref_head + i));
        end
    end
    target = commit_count + ref_rob.size();
    foreach (pending[k]) begin
        writeback(pending[k], 1'b0);
    end
    wait (commit_count >= target);
endtask

task automatic test_first_dispatch();
    dispatch_rsp_t first;
    dispatch_rsp_t second;
    dispatch_one(1'b1, arch_reg_t'(5), first);
    check_phys("disp_rsp_o.old_prf", first.old_prf, phys_reg_t'(5));
    check_phys("disp_rsp_o.new_prf", first.new_prf, phys_reg_t'(`ARCH_REGS));
    check_idx("disp_rsp_o.rob_idx", first.rob_idx, rob_idx_t'(0));
    dispatch_one(1'b1, arch_reg_t'(5), second);
    check_phys("disp_rsp_o.old_prf", second.old_prf, first.new_prf);
    drain();
endtask

task automatic test_out_of_order_commit();
    dispatch_rsp_t rsp;
    rob_idx_t      order [6];
    rob_idx_t      swap;
    int            j;
    int            target;
    for (int i = 0; i < 6; i++) begin
        dispatch_one(i != 4, arch_reg_t'(10 + i % 3), rsp);
        order[i] = rsp.rob_idx;
    end
    for (int i = 5; i > 0; i--) begin
        j        = int'($unsigned($random(seed)) % (i + 1));
        swap     = order[i];
        order[i] = order[j];
        order[j] = swap;
    end
    target = commit_count + 6;
    foreach (order[k]) begin
        writeback(order[k], 1'b0);
    end
    wait (commit_count >= target);
endtask

task automatic test_rob_full();
    dispatch_rsp_t rsp;
    rob_idx_t      first_idx;
    int            target;
    first_idx = ref_tail;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
        dispatch_one(1'b1, arch_reg_t'(i + 1), rsp);
    end
    step();
    disp_valid       = 1'b1;
    disp_req.rd_wen  = 1'b1;
    disp_req.rd_arch = arch_reg_t'(20);
    repeat (3) begin
        #1;
        check_bit("disp_ready_o", disp_ready, 1'b0);
        check_idx("disp_rsp_o.rob_idx", disp_rsp.rob_idx, first_idx);
        @(posedge clock);
        #10;
    end
    target = commit_count + 1;
    writeback(first_idx, 1'b0);
    wait (commit_count >= target);
    check_bit("disp_ready_o", disp_ready, 1'b1);
    dispatch_one(1'b1, arch_reg_t'(20), rsp);
    check_idx("disp_rsp_o.rob_idx", rsp.rob_idx, first_idx);
    drain();
endtask

task automatic test_free_recycle();
    dispatch_rsp_t a;
    dispatch_rsp_t b;
    dispatch_rsp_t c;
    dispatch_rsp_t d;
    dispatch_one(1'b1, arch_reg_t'(0), a);
    dispatch_one(1'b0, arch_reg_t'(8), b);
    dispatch_one(1'b1, arch_reg_t'(9), c);
    // No destination, so the register it reported is still the lowest
    check_phys("disp_rsp_o.new_prf", c.new_prf, b.new_prf);
    drain();
    // Arch 0 still held register 0, the lowest index once released
    dispatch_one(1'b1, arch_reg_t'(0), d);
    check_phys("disp_rsp_o.old_prf", d.old_prf, a.new_prf);
    check_phys("disp_rsp_o.new_prf", d.new_prf, phys_reg_t'(0));
    drain();
endtask

task automatic test_mispredict_flush();
    dispatch_rsp_t r0;
    dispatch_rsp_t r1;
    dispatch_rsp_t r2;
    dispatch_rsp_t after;
    int            commits;
    int            flushes;
    dispatch_one(1'b1, arch_reg_t'(4), r0);
    dispatch_one(1'b1, arch_reg_t'(6), r1);
    dispatch_one(1'b1, arch_reg_t'(4), r2);
    writeback(r2.rob_idx, 1'b0);
    writeback(r1.rob_idx, 1'b0);
    commits = commit_count;
    flushes = flush_count;
    writeback(r0.rob_idx, 1'b1);
    wait (flush_count > flushes);
    check_bit("disp_ready_o", disp_ready, 1'b0);
    check_idx("flush_idx_o", flush_idx, r0.rob_idx);
    repeat (3) step();
    if (commit_count != commits + 1) begin
        other_errors++;
        $display("Younger instructions committed after the flush at %0t", $time);
    end
    dispatch_one(1'b1, arch_reg_t'(4), after);
    check_phys("disp_rsp_o.old_prf", after.old_prf, r0.new_prf);
    drain();
endtask

// ==== bench/rename_retire_tb.sv ====
`include "rename_config.svh"

`default_nettype none

module rename_retire_tb
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Longest test runs about 60 cycles, five tests in all
    localparam int watchdog_cycles = 400;

    logic          clock;
    logic          reset;
    logic          disp_valid;
    dispatch_req_t disp_req;
    logic          disp_ready;
    dispatch_rsp_t disp_rsp;
    logic          wb_valid;
    wb_t           wb;
    logic          commit_valid;
    commit_t       commit;
    logic          flush;
    rob_idx_t      flush_idx;

    // Reference model state
    phys_reg_t             ref_spec_map   [`ARCH_REGS];
    phys_reg_t             ref_commit_map [`ARCH_REGS];
    logic [`PHYS_REGS-1:0] ref_spec_free;
    logic [`PHYS_REGS-1:0] ref_commit_free;
    rob_entry_t            ref_rob [$];
    rob_idx_t              ref_head;
    rob_idx_t              ref_tail;

    int     commit_count;
    int     flush_count;
    int     value_errors;
    int     other_errors;
    integer seed;

    rename_retire_top i_dut (
        .clock          (clock),
        .reset          (reset),
        .disp_valid_i   (disp_valid),
        .disp_req_i     (disp_req),
        .disp_ready_o   (disp_ready),
        .disp_rsp_o     (disp_rsp),
        .wb_valid_i     (wb_valid),
        .wb_i           (wb),
        .commit_valid_o (commit_valid),
        .commit_o       (commit),
        .flush_o        (flush),
        .flush_idx_o    (flush_idx)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_phys(input string name, input phys_reg_t got, input phys_reg_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %0t %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    task automatic check_commit(input string name, input commit_t got, input commit_t exp);
        string got_text;
        string exp_text;
        if (got !== exp) begin
            value_errors++;
            got_text = $sformatf("wen %0b arch %0d new %0d old %0d",
                                 got.rd_wen, got.rd_arch, got.new_prf, got.old_prf);
            exp_text = $sformatf("wen %0b arch %0d new %0d old %0d",
                                 exp.rd_wen, exp.rd_arch, exp.new_prf, exp.old_prf);
            $display("FAILED %0t %s got %s expected %s", $time, name, got_text, exp_text);
        end
    endtask

    // Identity map, registers from ARCH_REGS up free
    task automatic model_reset();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            ref_spec_map[i]   = phys_reg_t'(i);
            ref_commit_map[i] = phys_reg_t'(i);
        end
        ref_spec_free = '0;
        for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
            ref_spec_free[i] = 1'b1;
        end
        ref_commit_free = ref_spec_free;
        ref_rob.delete();
        ref_head = '0;
        ref_tail = '0;
    endtask

    function automatic phys_reg_t lowest_free();
        phys_reg_t found_prf;
        logic      found;
        found_prf = '0;
        found     = 1'b0;
        for (int i = 0; i < `PHYS_REGS; i++) begin
            if (!found && ref_spec_free[i]) begin
                found_prf = phys_reg_t'(i);
                found     = 1'b1;
            end
        end
        return found_prf;
    endfunction

    // Oldest model entry must match every commit
    task automatic check_retire();
        rob_entry_t oldest;
        if (ref_rob.size() == 0) begin
            other_errors++;
            $display("Commit at %0t with no instruction outstanding", $time);
        end else begin
            oldest = ref_rob.pop_front();
            if (!oldest.done) begin
                other_errors++;
                $display("Commit at %0t of an instruction never written back", $time);
            end
            check_commit("commit_o", commit, oldest.payload);
            check_bit("flush_o", flush, oldest.mispred || oldest.exception);
            commit_count++;
            if (oldest.payload.rd_wen) begin
                ref_commit_map[oldest.payload.rd_arch] = oldest.payload.new_prf;
                ref_commit_free[oldest.payload.old_prf] = 1'b1;
                ref_commit_free[oldest.payload.new_prf] = 1'b0;
                ref_spec_free[oldest.payload.old_prf]   = 1'b1;
            end
            if (oldest.mispred || oldest.exception) begin
                check_idx("flush_idx_o", flush_idx, ref_head);
                flush_count++;
                ref_rob.delete();
                ref_spec_map  = ref_commit_map;
                ref_spec_free = ref_commit_free;
                ref_head      = '0;
                ref_tail      = '0;
            end else begin
                ref_head = ref_head + 1'b1;
            end
        end
    endtask

    // Registered outputs, sampled mid cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (commit_valid) begin
                check_retire();
            end else if (flush) begin
                other_errors++;
                $display("Flush raised at %0t without a commit", $time);
            end
        end
    end

    `include "rename_retire_tests.svh"

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: tests still running after %0d clock cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed         = 32'hf389_42eb;
        commit_count = 0;
        flush_count  = 0;
        value_errors = 0;
        other_errors = 0;
        reset        = 1'b1;
        disp_valid   = 1'b0;
        disp_req     = '0;
        wb_valid     = 1'b0;
        wb           = '0;
        model_reset();
        repeat (3) @(posedge clock);
        #10;
        reset = 1'b0;

        test_first_dispatch();
        test_out_of_order_commit();
        test_rob_full();
        test_free_recycle();
        test_mispredict_flush();

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_retire.f ====
+incdir+verilog
+incdir+bench
verilog/rename_pkg.sv
verilog/reorder_buffer.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/rename_retire_top.sv
bench/rename_retire_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rename and retire testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rename_retire.f \
    --top-module rename_retire_tb \
    -o rename_retire_sim

sim_output=$(./obj_dir/rename_retire_sim)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== verilog/free_list.sv ====
`include "rename_config.svh"

`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  logic      alloc_i,
    output phys_reg_t free_prf_o,
    output logic      empty_o,

    input  logic      commit_valid_i,
    input  commit_t   commit_i,

    input  logic      flush_i
);

    // A set bit marks a free physical register
    localparam logic [`PHYS_REGS-1:0] free_at_reset =
        {{(`PHYS_REGS - `ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};

    if (`PHYS_REGS <= `ARCH_REGS) begin : g_size_check
        $error("PHYS_REGS must be larger than ARCH_REGS");
    end

    logic [`PHYS_REGS-1:0] spec_free;
    logic [`PHYS_REGS-1:0] commit_free;
    logic [`PHYS_REGS-1:0] spec_next;
    logic [`PHYS_REGS-1:0] commit_next;
    logic                  release_en;

    assign release_en = commit_valid_i && commit_i.rd_wen;
    assign empty_o    = ~|spec_free;

    // Lowest set bit wins
    always_comb begin
        free_prf_o = '0;
        for (int i = `PHYS_REGS - 1; i >= 0; i--) begin
            if (spec_free[i]) begin
                free_prf_o = phys_reg_t'(i);
            end
        end
    end

    always_comb begin
        commit_next = commit_free;
        if (release_en) begin
            commit_next[commit_i.old_prf] = 1'b1;
            commit_next[commit_i.new_prf] = 1'b0;
        end
    end

    always_comb begin
        spec_next = spec_free;
        if (alloc_i) begin
            spec_next[free_prf_o] = 1'b0;
        end
        if (release_en) begin
            spec_next[commit_i.old_prf] = 1'b1;
        end
        if (flush_i) begin
            spec_next = commit_next;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            spec_free   <= free_at_reset;
            commit_free <= free_at_reset;
        end else begin
            spec_free   <= spec_next;
            commit_free <= commit_next;
        end
    end

    a_no_alloc_empty: assert property (
        @(posedge clock) disable iff (reset)
        alloc_i |-> !empty_o
    ) else $error("free list allocation while empty");

    // Retiring old_prf must still be held by the committed state
    a_no_double_free: assert property (
        @(posedge clock) disable iff (reset)
        release_en |-> !commit_free[commit_i.old_prf]
    ) else $error("physical register freed twice");

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
`include "rename_config.svh"

`default_nettype none

module map_table
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // Current mapping of the incoming destination
    input  arch_reg_t lookup_arch_i,
    output phys_reg_t old_prf_o,

    // Speculative update at dispatch
    input  logic      rename_i,
    input  arch_reg_t rename_arch_i,
    input  phys_reg_t rename_prf_i,

    // Architectural update at retirement
    input  logic      commit_valid_i,
    input  commit_t   commit_i,

    input  logic      flush_i
);

    phys_reg_t spec_map   [`ARCH_REGS];
    phys_reg_t commit_map [`ARCH_REGS];

    phys_reg_t spec_next   [`ARCH_REGS];
    phys_reg_t commit_next [`ARCH_REGS];

    assign old_prf_o = spec_map[lookup_arch_i];

    always_comb begin
        commit_next = commit_map;
        if (commit_valid_i && commit_i.rd_wen) begin
            commit_next[commit_i.rd_arch] = commit_i.new_prf;
        end
    end

    // Restore sees the commit retiring in the flush cycle
    always_comb begin
        spec_next = spec_map;
        if (rename_i) begin
            spec_next[rename_arch_i] = rename_prf_i;
        end
        if (flush_i) begin
            spec_next = commit_next;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // Identity map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i]   <= phys_reg_t'(i);
                commit_map[i] <= phys_reg_t'(i);
            end
        end else begin
            spec_map   <= spec_next;
            commit_map <= commit_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Reorder buffer entries
// Power of two, so head and tail wrap on their own
`define ROB_DEPTH 16

// Architectural register count
`define ARCH_REGS 32

// Physical register count, always above ARCH_REGS
// The first ARCH_REGS of them hold the identity map out of reset
`define PHYS_REGS 64

`endif

// ==== verilog/rename_pkg.sv ====
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;
    // One extra bit so a full ROB is distinct from an empty one
    typedef logic [$clog2(`ROB_DEPTH):0]   rob_count_t;

    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
    } dispatch_req_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } dispatch_rsp_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        logic     exception;
        logic     mispred;
    } wb_t;

    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } commit_t;

    typedef struct packed {
        logic    valid;
        logic    done;
        logic    exception;
        logic    mispred;
        commit_t payload;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== verilog/rename_retire_top.sv ====
`default_nettype none

module rename_retire_top
    import rename_pkg::*;
(
    input  logic          clock,
    input  logic          reset,

    // Dispatch handshake
    input  logic          disp_valid_i,
    input  dispatch_req_t disp_req_i,
    output logic          disp_ready_o,
    output dispatch_rsp_t disp_rsp_o,

    // Completion
    input  logic          wb_valid_i,
    input  wb_t           wb_i,

    // Retirement
    output logic          commit_valid_o,
    output commit_t       commit_o,

    output logic          flush_o,
    output rob_idx_t      flush_idx_o
);

    logic      rob_full;
    logic      free_empty;
    phys_reg_t free_prf;
    phys_reg_t old_prf;
    rob_idx_t  rob_idx;
    logic      alloc_fire;
    logic      rename_fire;
    commit_t   alloc_entry;

    // A destination-less instruction can still go with no free register
    assign disp_ready_o = !rob_full && !flush_o && (!free_empty || !disp_req_i.rd_wen);
    assign alloc_fire   = disp_valid_i && disp_ready_o;
    assign rename_fire  = alloc_fire && disp_req_i.rd_wen;

    assign alloc_entry.rd_wen  = disp_req_i.rd_wen;
    assign alloc_entry.rd_arch = disp_req_i.rd_arch;
    assign alloc_entry.new_prf = free_prf;
    assign alloc_entry.old_prf = old_prf;

    assign disp_rsp_o.rob_idx = rob_idx;
    assign disp_rsp_o.new_prf = free_prf;
    assign disp_rsp_o.old_prf = old_prf;

    reorder_buffer i_rob (
        .clock          (clock),
        .reset          (reset),
        .alloc_i        (alloc_fire),
        .alloc_entry_i  (alloc_entry),
        .alloc_idx_o    (rob_idx),
        .full_o         (rob_full),
        .wb_valid_i     (wb_valid_i),
        .wb_i           (wb_i),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .flush_o        (flush_o),
        .flush_idx_o    (flush_idx_o)
    );

    map_table i_map (
        .clock          (clock),
        .reset          (reset),
        .lookup_arch_i  (disp_req_i.rd_arch),
        .old_prf_o      (old_prf),
        .rename_i       (rename_fire),
        .rename_arch_i  (disp_req_i.rd_arch),
        .rename_prf_i   (free_prf),
        .commit_valid_i (commit_valid_o),
        .commit_i       (commit_o),
        .flush_i        (flush_o)
    );

    free_list i_free (
        .clock          (clock),
        .reset          (reset),
        .alloc_i        (rename_fire),
        .free_prf_o     (free_prf),
        .empty_o        (free_empty),
        .commit_valid_i (commit_valid_o),
        .commit_i       (commit_o),
        .flush_i        (flush_o)
    );

endmodule

`default_nettype wire

// ==== verilog/reorder_buffer.sv ====
`include "rename_config.svh"

`default_nettype none

module reorder_buffer
    import rename_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    // Allocation at the tail
    input  logic       alloc_i,
    input  commit_t    alloc_entry_i,
    output rob_idx_t   alloc_idx_o,
    output logic       full_o,

    // Out of order completion
    input  logic       wb_valid_i,
    input  wb_t        wb_i,

    // In order retirement
    output logic       commit_valid_o,
    output commit_t    commit_o,

    output logic       flush_o,
    output rob_idx_t   flush_idx_o
);

    rob_entry_t entries [`ROB_DEPTH];

    rob_idx_t   head;
    rob_idx_t   tail;
    rob_count_t count;

    rob_entry_t head_entry;
    logic       retire_en;
    logic       head_marked;
    logic       flush_now;

    assign head_entry  = entries[head];
    assign retire_en   = head_entry.valid && head_entry.done;
    assign head_marked = head_entry.exception || head_entry.mispred;
    assign flush_now   = retire_en && head_marked;

    assign alloc_idx_o = tail;
    assign full_o      = (count == rob_count_t'(`ROB_DEPTH));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_valid_o <= 1'b0;
            flush_o        <= 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            commit_valid_o <= retire_en;
            flush_o        <= flush_now;

            if (wb_valid_i) begin
                entries[wb_i.rob_idx].done      <= 1'b1;
                entries[wb_i.rob_idx].exception <= wb_i.exception;
                entries[wb_i.rob_idx].mispred   <= wb_i.mispred;
            end

            if (alloc_i) begin
                entries[tail] <= rob_entry_t'{
                    valid:     1'b1,
                    done:      1'b0,
                    exception: 1'b0,
                    mispred:   1'b0,
                    payload:   alloc_entry_i
                };
                tail <= rob_idx_t'(tail + 1'b1);
            end

            if (retire_en) begin
                entries[head].valid <= 1'b0;
                head <= rob_idx_t'(head + 1'b1);
            end

            count <= count + rob_count_t'(alloc_i) - rob_count_t'(retire_en);

            // Marked head still retires, then every younger entry is dropped
            if (flush_now) begin
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    entries[i].valid <= 1'b0;
                    entries[i].done  <= 1'b0;
                end
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end
        end
    end

    // Retired payload, qualified by commit_valid_o and flush_o
    always_ff @(posedge clock) begin
        if (retire_en) begin
            commit_o    <= head_entry.payload;
            flush_idx_o <= head;
        end
    end

    // Completion must target a live entry
    a_wb_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        wb_valid_i |-> entries[wb_i.rob_idx].valid
    ) else $error("writeback to an empty ROB slot");

    // Dispatch ready upstream has to cover the full case
    a_no_alloc_full: assert property (
        @(posedge clock) disable iff (reset)
        alloc_i |-> !full_o
    ) else $error("ROB allocation while full");

endmodule

`default_nettype wire
